// File: rv_exec_cfg.svh
`ifndef RV_EXEC_CFG_SVH
`define RV_EXEC_CFG_SVH

// Datapath and program counter widths
`define XLEN 64
`define PC_W 32

// Width of one lookahead block in the adder
`define CLA_BLOCK_W 8

// Shift amounts, full and word forms
`define SHAMT_W 6
`define SHAMT_W32 5

`endif

// File: rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

    // Major opcodes, instruction bits [6:0]
    typedef enum logic [6:0] {
        OP        = 7'b0110011,
        OP_32     = 7'b0111011,
        OP_IMM    = 7'b0010011,
        OP_IMM_32 = 7'b0011011,
        LOAD      = 7'b0000011,
        STORE     = 7'b0100011,
        BRANCH    = 7'b1100011,
        JAL       = 7'b1101111,
        JALR      = 7'b1100111,
        AUIPC     = 7'b0010111,
        LUI       = 7'b0110111
    } opcode_e;

    // Arithmetic func3, shared by register, immediate and word forms
    typedef enum logic [2:0] {
        F3_ADD_SUB = 3'b000,
        F3_SLL     = 3'b001,
        F3_SLT     = 3'b010,
        F3_SLTU    = 3'b011,
        F3_XOR     = 3'b100,
        F3_SRL_SRA = 3'b101,
        F3_OR      = 3'b110,
        F3_AND     = 3'b111
    } alu_f3_e;

    // Conditional branch func3
    typedef enum logic [2:0] {
        F3_BEQ  = 3'b000,
        F3_BNE  = 3'b001,
        F3_BLT  = 3'b100,
        F3_BGE  = 3'b101,
        F3_BLTU = 3'b110,
        F3_BGEU = 3'b111
    } branch_f3_e;

    // F7_ALT selects sub and sra
    typedef enum logic [6:0] {
        F7_BASE = 7'b0000000,
        F7_ALT  = 7'b0100000
    } f7_e;

endpackage

`default_nettype wire

// File: exec_pkg.sv
`default_nettype none

`include "rv_exec_cfg.svh"

package exec_pkg;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B,
        ALU_ZERO
    } alu_op_e;

    typedef enum logic {
        OPA_RS1,
        OPA_PC
    } opa_sel_e;

    // OPB_UIMM is the U-type immediate, imm[19:0] << 12, sign-extended
    typedef enum logic [1:0] {
        OPB_RS2,
        OPB_IMM,
        OPB_UIMM
    } opb_sel_e;

    typedef struct packed {
        rv_isa_pkg::opcode_e   opcode;
        logic [2:0]            func3;
        rv_isa_pkg::f7_e       func7;
        logic [`XLEN-1:0]      imm;
        logic [`XLEN-1:0]      data1;
        logic [`XLEN-1:0]      data2;
        logic [`PC_W-1:0]      pc;
    } exec_in_t;

    typedef struct packed {
        alu_op_e  alu_op;
        opa_sel_e opa_sel;
        opb_sel_e opb_sel;
        logic     is_word;
        logic     is_branch_op;
        logic     is_jal;
        logic     is_jalr;
        logic     is_load;
        logic     mem_rw;
    } exec_ctrl_t;

    // mem_rw is 1 for a write
    typedef struct packed {
        logic [`XLEN-1:0] result;
        logic [`PC_W-1:0] pc_branch;
        logic             is_branch;
        logic             mem_rw;
        logic             is_load;
    } exec_out_t;

endpackage

`default_nettype wire

// File: cla_adder.sv
`default_nettype none

`include "rv_exec_cfg.svh"

module cla_adder (
    input  logic [`XLEN-1:0] a,
    input  logic [`XLEN-1:0] b,
    input  logic             cin,
    output logic [`XLEN-1:0] sum,
    output logic             cout
);

    localparam int W    = `CLA_BLOCK_W;
    localparam int NBLK = `XLEN / `CLA_BLOCK_W;

    logic [NBLK:0] blk_c;

    assign blk_c[0] = cin;

    for (genvar i = 0; i < NBLK; i++) begin : g_blk
        logic [W-1:0] p;
        logic [W-1:0] g;
        logic [W-1:0] gp;
        logic [W-1:0] pp;
        logic [W-1:0] c;

        assign p = a[i*W +: W] ^ b[i*W +: W];
        assign g = a[i*W +: W] & b[i*W +: W];

        // Group generate/propagate from bit 0 up to each bit
        always_comb begin
            gp[0] = g[0];
            pp[0] = p[0];
            for (int k = 1; k < W; k++) begin
                gp[k] = g[k] | (p[k] & gp[k-1]);
                pp[k] = p[k] & pp[k-1];
            end
        end

        // Every carry comes straight from the block carry-in
        assign c = {gp[W-2:0] | (pp[W-2:0] & {(W-1){blk_c[i]}}), blk_c[i]};
        assign sum[i*W +: W] = p ^ c;
        assign blk_c[i+1] = gp[W-1] | (pp[W-1] & blk_c[i]);
    end

    assign cout = blk_c[NBLK];

    always_comb begin
        if (!$isunknown({a, b, cin})) begin
            assert final ({cout, sum} == {1'b0, a} + {1'b0, b} + (`XLEN+1)'(cin))
                else $error("cla_adder sum mismatch");
        end
    end

endmodule

`default_nettype wire

// File: exec_decode.sv
`default_nettype none

module exec_decode (
    input  rv_isa_pkg::opcode_e  opcode,
    input  logic [2:0]           func3,
    input  rv_isa_pkg::f7_e      func7,
    output exec_pkg::exec_ctrl_t ctrl
);

    rv_isa_pkg::alu_f3_e f3;
    exec_pkg::alu_op_e   f3_op;
    logic                alt;

    assign f3  = rv_isa_pkg::alu_f3_e'(func3);
    assign alt = (func7 == rv_isa_pkg::F7_ALT);

    // func3 to operation, shared by register and immediate forms
    always_comb begin
        case (f3)
            rv_isa_pkg::F3_ADD_SUB: f3_op = exec_pkg::ALU_ADD;
            rv_isa_pkg::F3_SLL:     f3_op = exec_pkg::ALU_SLL;
            rv_isa_pkg::F3_SLT:     f3_op = exec_pkg::ALU_SLT;
            rv_isa_pkg::F3_SLTU:    f3_op = exec_pkg::ALU_SLTU;
            rv_isa_pkg::F3_XOR:     f3_op = exec_pkg::ALU_XOR;
            rv_isa_pkg::F3_SRL_SRA: f3_op = alt ? exec_pkg::ALU_SRA : exec_pkg::ALU_SRL;
            rv_isa_pkg::F3_OR:      f3_op = exec_pkg::ALU_OR;
            default:                f3_op = exec_pkg::ALU_AND;
        endcase
    end

    always_comb begin
        ctrl         = '0;
        ctrl.alu_op  = exec_pkg::ALU_ZERO;
        ctrl.opa_sel = exec_pkg::OPA_RS1;
        ctrl.opb_sel = exec_pkg::OPB_RS2;
        case (opcode)
            rv_isa_pkg::OP, rv_isa_pkg::OP_32: begin
                // Sub exists only in register forms
                if (f3 == rv_isa_pkg::F3_ADD_SUB && alt) begin
                    ctrl.alu_op = exec_pkg::ALU_SUB;
                end else begin
                    ctrl.alu_op = f3_op;
                end
                ctrl.is_word = (opcode == rv_isa_pkg::OP_32);
            end
            rv_isa_pkg::OP_IMM, rv_isa_pkg::OP_IMM_32: begin
                ctrl.alu_op  = f3_op;
                ctrl.opb_sel = exec_pkg::OPB_IMM;
                ctrl.is_word = (opcode == rv_isa_pkg::OP_IMM_32);
            end
            rv_isa_pkg::LOAD: begin
                ctrl.alu_op  = exec_pkg::ALU_ADD;
                ctrl.opb_sel = exec_pkg::OPB_IMM;
                ctrl.is_load = 1'b1;
            end
            rv_isa_pkg::STORE: begin
                ctrl.alu_op  = exec_pkg::ALU_ADD;
                ctrl.opb_sel = exec_pkg::OPB_IMM;
                ctrl.mem_rw  = 1'b1;
            end
            rv_isa_pkg::BRANCH: begin
                ctrl.is_branch_op = 1'b1;
            end
            rv_isa_pkg::JAL: begin
                ctrl.is_jal = 1'b1;
            end
            rv_isa_pkg::JALR: begin
                ctrl.is_jalr = 1'b1;
            end
            rv_isa_pkg::AUIPC: begin
                ctrl.alu_op  = exec_pkg::ALU_ADD;
                ctrl.opa_sel = exec_pkg::OPA_PC;
                ctrl.opb_sel = exec_pkg::OPB_UIMM;
            end
            rv_isa_pkg::LUI: begin
                ctrl.alu_op  = exec_pkg::ALU_PASS_B;
                ctrl.opb_sel = exec_pkg::OPB_UIMM;
            end
            default: begin
                // Unknown opcode, keep the zero result and clear flags
                ctrl.alu_op = exec_pkg::ALU_ZERO;
            end
        endcase
    end

    always_comb begin
        assert final (!(ctrl.is_load && ctrl.mem_rw))
            else $error("decode raised load and store together");
    end

endmodule

`default_nettype wire

// File: int_alu.sv
`default_nettype none

`include "rv_exec_cfg.svh"

module int_alu (
    input  exec_pkg::exec_ctrl_t ctrl,
    input  logic [`XLEN-1:0]     data1,
    input  logic [`XLEN-1:0]     data2,
    input  logic [`XLEN-1:0]     imm,
    input  logic [`PC_W-1:0]     pc,
    output logic [`XLEN-1:0]     alu_result
);

    logic [`XLEN-1:0]    opa;
    logic [`XLEN-1:0]    opb;
    logic [`XLEN-1:0]    opa_x;
    logic [`XLEN-1:0]    opb_x;
    logic [`XLEN-1:0]    add_b;
    logic [`XLEN-1:0]    sum;
    logic [`XLEN-1:0]    shift_src;
    logic [`XLEN-1:0]    res64;
    logic [`SHAMT_W-1:0] shamt;
    logic                sub;
    logic                cout;
    logic                lt_s;
    logic                lt_u;

    always_comb begin
        if (ctrl.opa_sel == exec_pkg::OPA_PC) begin
            opa = {{(`XLEN-`PC_W){1'b0}}, pc};
        end else begin
            opa = data1;
        end
        case (ctrl.opb_sel)
            exec_pkg::OPB_IMM:  opb = imm;
            exec_pkg::OPB_UIMM: opb = {{(`XLEN-32){imm[19]}}, imm[19:0], 12'b0};
            default:            opb = data2;
        endcase
    end

    // Word forms see sign-extended low halves
    assign opa_x = ctrl.is_word ? {{(`XLEN-32){opa[31]}}, opa[31:0]} : opa;
    assign opb_x = ctrl.is_word ? {{(`XLEN-32){opb[31]}}, opb[31:0]} : opb;

    // Sub and both compares run a - b through the adder
    assign sub = (ctrl.alu_op == exec_pkg::ALU_SUB) ||
                 (ctrl.alu_op == exec_pkg::ALU_SLT) ||
                 (ctrl.alu_op == exec_pkg::ALU_SLTU);
    assign add_b = sub ? ~opb_x : opb_x;

    cla_adder u_adder (
        .a    (opa_x),
        .b    (add_b),
        .cin  (sub),
        .sum  (sum),
        .cout (cout)
    );

    // No carry out means a borrow
    assign lt_u = ~cout;
    assign lt_s = (opa_x[`XLEN-1] ^ opb_x[`XLEN-1]) ? opa_x[`XLEN-1] : sum[`XLEN-1];

    assign shamt = ctrl.is_word ? `SHAMT_W'(opb[`SHAMT_W32-1:0]) : opb[`SHAMT_W-1:0];

    // Logical right shift of a word pulls in zeros above bit 31
    assign shift_src = (ctrl.is_word && ctrl.alu_op == exec_pkg::ALU_SRL) ?
                       {{(`XLEN-32){1'b0}}, opa[31:0]} : opa_x;

    always_comb begin
        case (ctrl.alu_op)
            exec_pkg::ALU_ADD,
            exec_pkg::ALU_SUB:    res64 = sum;
            exec_pkg::ALU_SLL:    res64 = shift_src << shamt;
            exec_pkg::ALU_SLT:    res64 = `XLEN'(lt_s);
            exec_pkg::ALU_SLTU:   res64 = `XLEN'(lt_u);
            exec_pkg::ALU_XOR:    res64 = opa_x ^ opb_x;
            exec_pkg::ALU_SRL:    res64 = shift_src >> shamt;
            exec_pkg::ALU_SRA:    res64 = $unsigned($signed(shift_src) >>> shamt);
            exec_pkg::ALU_OR:     res64 = opa_x | opb_x;
            exec_pkg::ALU_AND:    res64 = opa_x & opb_x;
            exec_pkg::ALU_PASS_B: res64 = opb_x;
            default:              res64 = '0;
        endcase
    end

    assign alu_result = ctrl.is_word ? {{(`XLEN-32){res64[31]}}, res64[31:0]} : res64;

endmodule

`default_nettype wire

// File: branch_unit.sv
`default_nettype none

`include "rv_exec_cfg.svh"

module branch_unit (
    input  exec_pkg::exec_ctrl_t    ctrl,
    input  rv_isa_pkg::branch_f3_e  func3,
    input  logic [`XLEN-1:0]        data1,
    input  logic [`XLEN-1:0]        data2,
    input  logic [`XLEN-1:0]        imm,
    input  logic [`PC_W-1:0]        pc,
    output logic [`PC_W-1:0]        pc_branch,
    output logic                    taken,
    output logic [`XLEN-1:0]        link
);

    logic [`XLEN-1:0] pc_x;
    logic [`XLEN-1:0] tgt_base;
    logic [`XLEN-1:0] target;
    logic [`XLEN-1:0] pc_plus4;
    logic             cond;

    assign pc_x     = {{(`XLEN-`PC_W){1'b0}}, pc};
    assign tgt_base = ctrl.is_jalr ? data1 : pc_x;

    cla_adder u_tgt_adder (
        .a    (tgt_base),
        .b    (imm),
        .cin  (1'b0),
        .sum  (target),
        .cout ()
    );

    cla_adder u_pc4_adder (
        .a    (pc_x),
        .b    (`XLEN'(4)),
        .cin  (1'b0),
        .sum  (pc_plus4),
        .cout ()
    );

    always_comb begin
        case (func3)
            rv_isa_pkg::F3_BEQ:  cond = (data1 == data2);
            rv_isa_pkg::F3_BNE:  cond = (data1 != data2);
            rv_isa_pkg::F3_BLT:  cond = ($signed(data1) < $signed(data2));
            rv_isa_pkg::F3_BGE:  cond = ($signed(data1) >= $signed(data2));
            rv_isa_pkg::F3_BLTU: cond = (data1 < data2);
            rv_isa_pkg::F3_BGEU: cond = (data1 >= data2);
            default:             cond = 1'b0;
        endcase
    end

    // Jumps always redirect
    assign taken = ctrl.is_jal | ctrl.is_jalr | (ctrl.is_branch_op & cond);

    assign pc_branch = taken ? target[`PC_W-1:0] : pc_plus4[`PC_W-1:0];
    assign link      = pc_plus4;

endmodule

`default_nettype wire

// File: exec_unit.sv
`default_nettype none

`include "rv_exec_cfg.svh"

module exec_unit (
    input  logic                clk,
    input  logic                rst,
    input  exec_pkg::exec_in_t  op,
    output exec_pkg::exec_out_t res
);

    exec_pkg::exec_ctrl_t ctrl;
    exec_pkg::exec_out_t  res_d;
    logic [`XLEN-1:0]     alu_result;
    logic [`XLEN-1:0]     link;
    logic [`PC_W-1:0]     pc_branch;
    logic                 taken;

    exec_decode u_decode (
        .opcode (op.opcode),
        .func3  (op.func3),
        .func7  (op.func7),
        .ctrl   (ctrl)
    );

    int_alu u_alu (
        .ctrl       (ctrl),
        .data1      (op.data1),
        .data2      (op.data2),
        .imm        (op.imm),
        .pc         (op.pc),
        .alu_result (alu_result)
    );

    branch_unit u_branch (
        .ctrl      (ctrl),
        .func3     (rv_isa_pkg::branch_f3_e'(op.func3)),
        .data1     (op.data1),
        .data2     (op.data2),
        .imm       (op.imm),
        .pc        (op.pc),
        .pc_branch (pc_branch),
        .taken     (taken),
        .link      (link)
    );

    // Jumps write the link, everything else the ALU
    always_comb begin
        res_d.result    = (ctrl.is_jal || ctrl.is_jalr) ? link : alu_result;
        res_d.pc_branch = pc_branch;
        res_d.is_branch = taken;
        res_d.mem_rw    = ctrl.mem_rw;
        res_d.is_load   = ctrl.is_load;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            res <= '0;
        end else begin
            res <= res_d;
        end
    end

    // A jump leaves pc+4 in result one cycle later
    assert property (@(posedge clk) disable iff (rst)
        (ctrl.is_jal || ctrl.is_jalr) |=>
            res.result == $past(`XLEN'(op.pc) + `XLEN'(4)))
        else $error("jump link is not pc+4");

    // Loads and stores address memory at data1+imm
    assert property (@(posedge clk) disable iff (rst)
        (ctrl.is_load || ctrl.mem_rw) |=> res.result == $past(op.data1 + op.imm))
        else $error("memory address is not data1+imm");

endmodule

`default_nettype wire

// File: tb_exec_unit.sv
`default_nettype none

`include "rv_exec_cfg.svh"

module tb_exec_unit;

    typedef struct packed {
        exec_pkg::exec_in_t  in;
        exec_pkg::exec_out_t exp;
    } entry_t;

    logic                clk;
    logic                rst;
    exec_pkg::exec_in_t  op;
    exec_pkg::exec_out_t res;
    int                  cycles;
    entry_t              table_q[$];

    exec_unit u_exec_unit (
        .clk (clk),
        .rst (rst),
        .op  (op),
        .res (res)
    );

    // Cycle count moves before the rising edge so waiters see it
    initial begin
        clk    = 1'b0;
        cycles = 0;
        forever begin
            #2;
            if (!clk) begin
                cycles++;
            end
            clk = ~clk;
        end
    end

    // Expected outputs straight from the RV64I rules
    function automatic exec_pkg::exec_out_t model(exec_pkg::exec_in_t t);
        exec_pkg::exec_out_t o;
        logic [63:0]         a;
        logic [63:0]         b;
        logic [63:0]         r;
        logic [63:0]         uimm;
        logic [63:0]         pc4;
        logic [5:0]          sh;
        logic                word;
        logic                alt;
        logic                regf;
        logic                cond;
        o    = '0;
        r    = '0;
        cond = 1'b0;
        alt  = (t.func7 == rv_isa_pkg::F7_ALT);
        pc4  = {32'b0, t.pc} + 64'd4;
        uimm = {{32{t.imm[19]}}, t.imm[19:0], 12'b0};
        o.pc_branch = pc4[31:0];
        case (t.opcode)
            rv_isa_pkg::OP, rv_isa_pkg::OP_32, rv_isa_pkg::OP_IMM, rv_isa_pkg::OP_IMM_32: begin
                regf = (t.opcode == rv_isa_pkg::OP) || (t.opcode == rv_isa_pkg::OP_32);
                word = (t.opcode == rv_isa_pkg::OP_32) || (t.opcode == rv_isa_pkg::OP_IMM_32);
                a    = t.data1;
                b    = regf ? t.data2 : t.imm;
                sh   = word ? {1'b0, b[4:0]} : b[5:0];
                if (word) begin
                    a = {{32{a[31]}}, a[31:0]};
                    b = {{32{b[31]}}, b[31:0]};
                end
                case (t.func3)
                    3'b000: r = (regf && alt) ? a - b : a + b;
                    3'b001: r = a << sh;
                    3'b010: r = {63'b0, $signed(a) < $signed(b)};
                    3'b011: r = {63'b0, a < b};
                    3'b100: r = a ^ b;
                    3'b101: begin
                        if (alt) begin
                            r = $unsigned($signed(a) >>> sh);
                        end else if (word) begin
                            r = {32'b0, a[31:0]} >> sh;
                        end else begin
                            r = a >> sh;
                        end
                    end
                    3'b110: r = a | b;
                    default: r = a & b;
                endcase
                if (word) begin
                    r = {{32{r[31]}}, r[31:0]};
                end
            end
            rv_isa_pkg::LOAD: begin
                r = t.data1 + t.imm;
                o.is_load = 1'b1;
            end
            rv_isa_pkg::STORE: begin
                r = t.data1 + t.imm;
                o.mem_rw = 1'b1;
            end
            rv_isa_pkg::LUI:   r = uimm;
            rv_isa_pkg::AUIPC: r = {32'b0, t.pc} + uimm;
            rv_isa_pkg::BRANCH: begin
                case (t.func3)
                    3'b000: cond = (t.data1 == t.data2);
                    3'b001: cond = (t.data1 != t.data2);
                    3'b100: cond = ($signed(t.data1) < $signed(t.data2));
                    3'b101: cond = ($signed(t.data1) >= $signed(t.data2));
                    3'b110: cond = (t.data1 < t.data2);
                    3'b111: cond = (t.data1 >= t.data2);
                    default: cond = 1'b0;
                endcase
                if (cond) begin
                    o.is_branch = 1'b1;
                    o.pc_branch = t.pc + t.imm[31:0];
                end
            end
            rv_isa_pkg::JAL: begin
                r = pc4;
                o.is_branch = 1'b1;
                o.pc_branch = t.pc + t.imm[31:0];
            end
            rv_isa_pkg::JALR: begin
                r = pc4;
                o.is_branch = 1'b1;
                o.pc_branch = t.data1[31:0] + t.imm[31:0];
            end
            default: r = '0;
        endcase
        o.result = r;
        return o;
    endfunction

    task automatic add_entry(input logic [6:0] opc, input logic [2:0] f3, input logic f7_alt,
                             input logic [63:0] imm, input logic [63:0] d1,
                             input logic [63:0] d2, input logic [31:0] pc);
        entry_t e;
        e.in.opcode = rv_isa_pkg::opcode_e'(opc);
        e.in.func3  = f3;
        e.in.func7  = f7_alt ? rv_isa_pkg::F7_ALT : rv_isa_pkg::F7_BASE;
        e.in.imm    = imm;
        e.in.data1  = d1;
        e.in.data2  = d2;
        e.in.pc     = pc;
        e.exp       = model(e.in);
        table_q.push_back(e);
    endtask

    // Returns one unit after the next rising edge
    task automatic next_cycle;
        int start;
        int n;
        start = cycles;
        n     = 0;
        while (cycles == start && n < 4) begin
            @(clk);
            n++;
        end
        if (cycles == start) begin
            $display("Timed out waiting for the clock edge");
            $display("** FAIL **");
            $fatal(1);
        end
        #1;
    endtask

    task automatic check_outputs(input exec_pkg::exec_out_t exp);
        assert (res.result == exp.result) else begin
            $display("Fail result got %h expected %h", res.result, exp.result);
            $display("** FAIL **");
            $fatal(1);
        end
        assert (res.pc_branch == exp.pc_branch) else begin
            $display("Fail pc_branch got %h expected %h", res.pc_branch, exp.pc_branch);
            $display("** FAIL **");
            $fatal(1);
        end
        assert ({res.is_branch, res.mem_rw, res.is_load} ==
                {exp.is_branch, exp.mem_rw, exp.is_load}) else begin
            $display("Fail flags {is_branch,mem_rw,is_load} got %h expected %h",
                     {res.is_branch, res.mem_rw, res.is_load},
                     {exp.is_branch, exp.mem_rw, exp.is_load});
            $display("** FAIL **");
            $fatal(1);
        end
    endtask

    task automatic build_directed;
        // Sub borrow through every block, then sra against srl
        add_entry(7'b0110011, 3'b000, 1'b1, 64'h0, 64'h0, 64'h1, 32'h100);
        add_entry(7'b0110011, 3'b000, 1'b1, 64'h0, 64'h1000_0000_0000_0000, 64'h1, 32'h0);
        add_entry(7'b0110011, 3'b101, 1'b1, 64'h0, 64'h8000_0000_0000_0010, 64'h4, 32'h0);
        add_entry(7'b0110011, 3'b101, 1'b0, 64'h0, 64'h8000_0000_0000_0010, 64'h4, 32'h0);
        add_entry(7'b0010011, 3'b010, 1'b0, 64'hFFFF_FFFF_FFFF_FFFF, 64'h5, 64'h0, 32'h0);
        add_entry(7'b0010011, 3'b011, 1'b0, 64'hFFFF_FFFF_FFFF_FFFF, 64'h5, 64'h0, 32'h0);
        // Word forms sign-extend bit 31
        add_entry(7'b0111011, 3'b000, 1'b0, 64'h0, 64'h7FFF_FFFF, 64'h1, 32'h0);
        add_entry(7'b0011011, 3'b101, 1'b1, 64'h4, 64'h8000_0000, 64'h0, 32'h0);
        add_entry(7'b0011011, 3'b101, 1'b0, 64'h4, 64'hFFFF_FFFF_8000_0000, 64'h0, 32'h0);
        add_entry(7'b0111011, 3'b001, 1'b0, 64'h0, 64'h1, 64'h3F, 32'h0);
        add_entry(7'b0110111, 3'b000, 1'b0, 64'h8_0000, 64'h0, 64'h0, 32'h40);
        add_entry(7'b0010111, 3'b000, 1'b0, 64'h1_2345, 64'h0, 64'h0, 32'h8000_1000);
        add_entry(7'b0000011, 3'b011, 1'b0, 64'hFFFF_FFFF_FFFF_FFF8, 64'h2000, 64'h0, 32'h0);
        add_entry(7'b0100011, 3'b011, 1'b0, 64'h18, 64'h2000, 64'h55, 32'h0);
        // Each branch taken and not taken
        add_entry(7'b1100011, 3'b000, 1'b0, 64'h20, 64'h7, 64'h7, 32'h1000);
        add_entry(7'b1100011, 3'b000, 1'b0, 64'h20, 64'h7, 64'h8, 32'h1000);
        add_entry(7'b1100011, 3'b001, 1'b0, 64'hFFFF_FFFF_FFFF_FFF0, 64'h7, 64'h8, 32'h1000);
        add_entry(7'b1100011, 3'b001, 1'b0, 64'h20, 64'h7, 64'h7, 32'h1000);
        add_entry(7'b1100011, 3'b100, 1'b0, 64'h40, 64'hFFFF_FFFF_FFFF_FFFF, 64'h1, 32'h2000);
        add_entry(7'b1100011, 3'b100, 1'b0, 64'h40, 64'h1, 64'hFFFF_FFFF_FFFF_FFFF, 32'h2000);
        add_entry(7'b1100011, 3'b101, 1'b0, 64'h40, 64'h1, 64'hFFFF_FFFF_FFFF_FFFF, 32'h2000);
        add_entry(7'b1100011, 3'b101, 1'b0, 64'h40, 64'hFFFF_FFFF_FFFF_FFFF, 64'h1, 32'h2000);
        add_entry(7'b1100011, 3'b110, 1'b0, 64'h80, 64'h1, 64'hFFFF_FFFF_FFFF_FFFF, 32'h3000);
        add_entry(7'b1100011, 3'b110, 1'b0, 64'h80, 64'hFFFF_FFFF_FFFF_FFFF, 64'h1, 32'h3000);
        add_entry(7'b1100011, 3'b111, 1'b0, 64'h80, 64'hFFFF_FFFF_FFFF_FFFF, 64'h1, 32'h3000);
        add_entry(7'b1100011, 3'b111, 1'b0, 64'h80, 64'h1, 64'hFFFF_FFFF_FFFF_FFFF, 32'h3000);
        add_entry(7'b1101111, 3'b000, 1'b0, 64'h800, 64'h0, 64'h0, 32'h4000);
        add_entry(7'b1100111, 3'b000, 1'b0, 64'h10, 64'h9000, 64'h0, 32'h4000);
        add_entry(7'b1111111, 3'b010, 1'b1, 64'h33, 64'h44, 64'h55, 32'h5000);
    endtask

    task automatic build_random;
        logic [6:0] opcs[12];
        logic [2:0] wf3[3];
        logic [2:0] bf3[6];
        logic [6:0] opc;
        logic [2:0] f3;
        logic [63:0] d1;
        logic [63:0] d2;
        opcs = '{7'b0110011, 7'b0111011, 7'b0010011, 7'b0011011, 7'b0000011, 7'b0100011,
                 7'b1100011, 7'b1101111, 7'b1100111, 7'b0010111, 7'b0110111, 7'b1111111};
        wf3  = '{3'b000, 3'b001, 3'b101};
        bf3  = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
        for (int i = 0; i < 200; i++) begin
            opc = opcs[$urandom % 12];
            f3  = 3'($urandom);
            if (opc == 7'b0111011 || opc == 7'b0011011) begin
                f3 = wf3[$urandom % 3];
            end else if (opc == 7'b1100011) begin
                f3 = bf3[$urandom % 6];
            end
            d1 = {$urandom, $urandom};
            d2 = ($urandom % 4 == 0) ? d1 : {$urandom, $urandom};
            add_entry(opc, f3, 1'($urandom), {$urandom, $urandom}, d1, d2, $urandom);
        end
    endtask

    initial begin
        void'($urandom(37127));
        rst = 1'b1;
        op  = '0;
        build_directed();
        build_random();
        for (int i = 0; i < 3; i++) begin
            next_cycle();
            check_outputs('0);
        end
        rst = 1'b0;
        op  = table_q[0].in;
        // Half a cycle on, the new operation must not have reached res
        #2;
        check_outputs('0);
        foreach (table_q[i]) begin
            op = table_q[i].in;
            next_cycle();
            check_outputs(table_q[i].exp);
        end
        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire

// File: exec_unit.f
+incdir+.
rv_isa_pkg.sv
exec_pkg.sv
cla_adder.sv
exec_decode.sv
int_alu.sv
branch_unit.sv
exec_unit.sv
tb_exec_unit.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f exec_unit.f --top-module tb_exec_unit -o sim_exec_unit

out=$(./obj_dir/sim_exec_unit)
echo "$out"

if echo "$out" | grep -qF "** PASS **"; then
    exit 0
fi
exit 1
